//--- logic/msu_pkg.sv
package msu_pkg;

  //////////////////////////////
  // Widths with a meaning
  //////////////////////////////

  // One register or buffer byte
  typedef logic [7:0] msu_byte_t;

  // 16 KB data buffer address
  typedef logic [13:0] msu_buf_addr_t;

  // Console register select for eight registers
  typedef logic [2:0] msu_reg_sel_t;

  // Seek offset and track number handed to the MCU
  typedef logic [31:0] msu_seek_t;
  typedef logic [15:0] msu_track_t;

  // MCU set/clear mask
  // 5 audio busy, 4 data busy, 3 audio error, 2:1 play/repeat, 0 control request
  typedef logic [5:0] msu_flags_t;

  //////////////////////////////
  // ID string and revision
  //////////////////////////////

  // "S-MSU1" in registers 2 to 7
  localparam msu_byte_t MSU_ID0 = 8'h53;
  localparam msu_byte_t MSU_ID1 = 8'h2D;
  localparam msu_byte_t MSU_ID2 = 8'h4D;
  localparam msu_byte_t MSU_ID3 = 8'h53;
  localparam msu_byte_t MSU_ID4 = 8'h55;
  localparam msu_byte_t MSU_ID5 = 8'h31;

  // Low bits of the status byte
  localparam logic [2:0] MSU_REVISION = 3'd1;

endpackage

//--- logic/msu_bus_edge.sv
module msu_bus_edge #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clkin,
  input  logic reset,
  input  logic snes_rd,
  input  logic snes_wr,
  input  logic ext_addr_write,
  input  logic status_write,
  output logic rd_start,
  output logic wr_end,
  output logic addr_load,
  output logic flags_load
);

  localparam int NUM_LINES = 4;
  // Only the console write strobe acts on its falling edge
  localparam logic [NUM_LINES-1:0] FALL_EDGE = 4'b0010;

  logic [NUM_LINES-1:0] level_in;
  logic [NUM_LINES-1:0] level_sync;
  logic [NUM_LINES-1:0] level_hist;
  logic [NUM_LINES-1:0] edge_seen;
  logic [NUM_LINES-1:0] pulse_q;

  assign level_in = {status_write, ext_addr_write, snes_wr, snes_rd};

  genvar i;
  generate
    for (i = 0; i < NUM_LINES; i++) begin : g_line
      logic [SYNC_STAGES-1:0] chain;

      always_ff @(posedge clkin) begin
        if (reset) begin
          chain <= '0;
        end else begin
          chain <= (chain << 1) | SYNC_STAGES'(level_in[i]);
        end
      end

      assign level_sync[i] = chain[SYNC_STAGES-1];
      assign edge_seen[i] = FALL_EDGE[i] ? (level_hist[i] & ~level_sync[i])
                                         : (level_sync[i] & ~level_hist[i]);
    end
  endgenerate

  // History flop plus a one-cycle registered pulse
  always_ff @(posedge clkin) begin
    if (reset) begin
      level_hist <= '0;
      pulse_q    <= '0;
    end else begin
      level_hist <= level_sync;
      pulse_q    <= edge_seen;
    end
  end

  assign rd_start   = pulse_q[0];
  assign wr_end     = pulse_q[1];
  assign addr_load  = pulse_q[2];
  assign flags_load = pulse_q[3];

endmodule

//--- logic/msu_regs.sv
module msu_regs (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   enable,
  input  logic                   rd_start,
  input  logic                   wr_end,
  input  logic                   addr_load,
  input  logic                   flags_load,
  input  msu_pkg::msu_reg_sel_t  reg_addr,
  input  msu_pkg::msu_byte_t     reg_data_in,
  input  msu_pkg::msu_buf_addr_t msu_address_ext,
  input  msu_pkg::msu_flags_t    status_set_bits,
  input  msu_pkg::msu_flags_t    status_reset_bits,
  input  logic                   buf_rd_grant,
  input  logic                   buf_rd_valid,
  input  msu_pkg::msu_byte_t     buf_rd_data,
  output msu_pkg::msu_byte_t     reg_data_out,
  output msu_pkg::msu_byte_t     status_out,
  output msu_pkg::msu_byte_t     volume_out,
  output logic                   volume_latch_out,
  output msu_pkg::msu_seek_t     addr_out,
  output msu_pkg::msu_track_t    track_out,
  output msu_pkg::msu_buf_addr_t buf_rd_addr,
  output logic                   buf_rd_req
);

  // Bit positions inside the MCU flag word
  localparam int F_AUDIO_BUSY = 5;
  localparam int F_DATA_BUSY  = 4;
  localparam int F_AUDIO_ERR  = 3;
  localparam int F_CTRL_REQ   = 0;

  msu_pkg::msu_flags_t    flags;
  msu_pkg::msu_flags_t    flags_next;
  msu_pkg::msu_buf_addr_t buf_addr;
  msu_pkg::msu_byte_t     prefetch_byte;
  logic                   audio_start;
  logic                   data_start;
  logic                   volume_latch;
  logic [2:0]             audio_ctrl;
  logic                   console_rd;
  logic                   console_wr;
  logic                   addr_step;

  assign console_rd = rd_start & enable;
  assign console_wr = wr_end & enable;
  assign addr_step  = console_rd & (reg_addr == 3'd1);

  // Set first, then clear
  assign flags_next = (flags | status_set_bits) & ~status_reset_bits;

  //////////////////////////////
  // Console reads
  //////////////////////////////

  always_ff @(posedge clkin) begin
    if (console_rd) begin
      case (reg_addr)
        3'd0: reg_data_out <= {flags[F_DATA_BUSY], flags[F_AUDIO_BUSY], flags[2:1],
                               flags[F_AUDIO_ERR], msu_pkg::MSU_REVISION};
        3'd1: reg_data_out <= prefetch_byte;
        3'd2: reg_data_out <= msu_pkg::MSU_ID0;
        3'd3: reg_data_out <= msu_pkg::MSU_ID1;
        3'd4: reg_data_out <= msu_pkg::MSU_ID2;
        3'd5: reg_data_out <= msu_pkg::MSU_ID3;
        3'd6: reg_data_out <= msu_pkg::MSU_ID4;
        3'd7: reg_data_out <= msu_pkg::MSU_ID5;
      endcase
    end
  end

  //////////////////////////////
  // Buffer address and prefetch
  //////////////////////////////

  // MCU load beats the read increment; wraps at 0x3FFF
  always_ff @(posedge clkin) begin
    if (reset) begin
      buf_addr   <= '0;
      buf_rd_req <= 1'b0;
    end else if (addr_load) begin
      buf_addr   <= msu_address_ext;
      buf_rd_req <= 1'b1;
    end else if (addr_step) begin
      buf_addr   <= buf_addr + 1'b1;
      buf_rd_req <= 1'b1;
    end else if (buf_rd_grant) begin
      buf_rd_req <= 1'b0;
    end
  end

  assign buf_rd_addr = buf_addr;

  // Byte served on the next register 1 read
  always_ff @(posedge clkin) begin
    if (buf_rd_valid) begin
      prefetch_byte <= buf_rd_data;
    end
  end

  //////////////////////////////
  // Console writes, MCU flags
  //////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset) begin
      flags       <= 6'b11_0000;
      audio_start <= 1'b0;
      data_start  <= 1'b0;
      audio_ctrl  <= '0;
      addr_out    <= '0;
      track_out   <= '0;
      volume_out  <= '0;
    end else if (console_wr) begin
      case (reg_addr)
        3'd0: addr_out[7:0]   <= reg_data_in;
        3'd1: addr_out[15:8]  <= reg_data_in;
        3'd2: addr_out[23:16] <= reg_data_in;
        3'd3: begin
          addr_out[31:24]    <= reg_data_in;
          data_start         <= 1'b1;
          flags[F_DATA_BUSY] <= 1'b1;
        end
        3'd4: track_out[7:0] <= reg_data_in;
        3'd5: begin
          track_out[15:8]     <= reg_data_in;
          audio_start         <= 1'b1;
          flags[F_AUDIO_BUSY] <= 1'b1;
        end
        3'd6: volume_out <= reg_data_in;
        3'd7: begin
          // Control is locked out while audio is busy
          if (!flags[F_AUDIO_BUSY]) begin
            audio_ctrl        <= reg_data_in[2:0];
            flags[F_CTRL_REQ] <= 1'b1;
          end
        end
      endcase
    end else if (flags_load) begin
      flags <= flags_next;
      if (status_reset_bits[F_AUDIO_BUSY]) begin
        audio_start <= 1'b0;
      end
      if (status_reset_bits[F_DATA_BUSY]) begin
        data_start <= 1'b0;
      end
    end
  end

  // One cycle per volume write
  always_ff @(posedge clkin) begin
    if (reset) begin
      volume_latch <= 1'b0;
    end else begin
      volume_latch <= console_wr & (reg_addr == 3'd6);
    end
  end

  assign volume_latch_out = volume_latch;

  assign status_out = {buf_addr[13], audio_start, data_start, volume_latch,
                       audio_ctrl, flags[F_CTRL_REQ]};

endmodule

//--- logic/msu_buf_arbiter.sv
module msu_buf_arbiter (
  input  logic                   clkin,
  input  logic                   reset,
  input  logic                   pgm_we,
  input  msu_pkg::msu_buf_addr_t pgm_address,
  input  msu_pkg::msu_byte_t     pgm_data,
  input  logic                   buf_rd_req,
  input  msu_pkg::msu_buf_addr_t buf_rd_addr,
  output logic                   buf_rd_grant,
  output logic                   buf_rd_valid,
  output logic                   ram_we,
  output msu_pkg::msu_buf_addr_t ram_addr,
  output msu_pkg::msu_byte_t     ram_wdata
);

  logic                   wr_pending;
  logic                   wr_grant;
  msu_pkg::msu_buf_addr_t wr_addr;
  msu_pkg::msu_byte_t     wr_data;

  // One-entry hold for the MCU fill write
  always_ff @(posedge clkin) begin
    if (pgm_we) begin
      wr_addr <= pgm_address;
      wr_data <= pgm_data;
    end
  end

  always_ff @(posedge clkin) begin
    if (reset) begin
      wr_pending <= 1'b0;
    end else if (pgm_we) begin
      wr_pending <= 1'b1;
    end else if (wr_grant) begin
      wr_pending <= 1'b0;
    end
  end

  // Reads always win; a held write slips by at most one cycle
  assign buf_rd_grant = buf_rd_req;
  assign wr_grant     = wr_pending & ~buf_rd_req;

  assign ram_we    = wr_grant;
  assign ram_addr  = buf_rd_grant ? buf_rd_addr : wr_addr;
  assign ram_wdata = wr_data;

  // RAM output is registered, so data follows the grant by one cycle
  always_ff @(posedge clkin) begin
    if (reset) begin
      buf_rd_valid <= 1'b0;
    end else begin
      buf_rd_valid <= buf_rd_grant;
    end
  end

endmodule

//--- logic/msu_databuf.sv
module msu_databuf (
  input  logic                   clkin,
  input  logic                   we,
  input  msu_pkg::msu_buf_addr_t addr,
  input  msu_pkg::msu_byte_t     wdata,
  output msu_pkg::msu_byte_t     rdata
);

  localparam int DEPTH = 1 << $bits(msu_pkg::msu_buf_addr_t);

  msu_pkg::msu_byte_t mem [DEPTH];

  // Single port with a registered read
  always_ff @(posedge clkin) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- logic/msu_top.sv
module msu_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                   clkin,
  input  logic                   reset,
  // Console side
  input  logic                   snes_rd,
  input  logic                   snes_wr,
  input  logic                   enable,
  input  msu_pkg::msu_reg_sel_t  reg_addr,
  input  msu_pkg::msu_byte_t     reg_data_in,
  output msu_pkg::msu_byte_t     reg_data_out,
  // MCU side
  input  msu_pkg::msu_buf_addr_t pgm_address,
  input  msu_pkg::msu_byte_t     pgm_data,
  input  logic                   pgm_we,
  input  msu_pkg::msu_buf_addr_t msu_address_ext,
  input  logic                   msu_address_ext_write,
  input  msu_pkg::msu_flags_t    status_set_bits,
  input  msu_pkg::msu_flags_t    status_reset_bits,
  input  logic                   status_reset_we,
  output msu_pkg::msu_byte_t     status_out,
  output msu_pkg::msu_seek_t     addr_out,
  output msu_pkg::msu_track_t    track_out,
  output msu_pkg::msu_byte_t     volume_out,
  output logic                   volume_latch_out
);

  logic                   rd_start;
  logic                   wr_end;
  logic                   addr_load;
  logic                   flags_load;
  logic                   buf_rd_req;
  logic                   buf_rd_grant;
  logic                   buf_rd_valid;
  msu_pkg::msu_buf_addr_t buf_rd_addr;
  msu_pkg::msu_byte_t     buf_rd_data;
  logic                   ram_we;
  msu_pkg::msu_buf_addr_t ram_addr;
  msu_pkg::msu_byte_t     ram_wdata;

  msu_bus_edge #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_edge (
    .clkin(clkin),
    .reset(reset),
    .snes_rd(snes_rd),
    .snes_wr(snes_wr),
    .ext_addr_write(msu_address_ext_write),
    .status_write(status_reset_we),
    .rd_start(rd_start),
    .wr_end(wr_end),
    .addr_load(addr_load),
    .flags_load(flags_load)
  );

  msu_regs u_regs (
    .clkin(clkin),
    .reset(reset),
    .enable(enable),
    .rd_start(rd_start),
    .wr_end(wr_end),
    .addr_load(addr_load),
    .flags_load(flags_load),
    .reg_addr(reg_addr),
    .reg_data_in(reg_data_in),
    .msu_address_ext(msu_address_ext),
    .status_set_bits(status_set_bits),
    .status_reset_bits(status_reset_bits),
    .buf_rd_grant(buf_rd_grant),
    .buf_rd_valid(buf_rd_valid),
    .buf_rd_data(buf_rd_data),
    .reg_data_out(reg_data_out),
    .status_out(status_out),
    .volume_out(volume_out),
    .volume_latch_out(volume_latch_out),
    .addr_out(addr_out),
    .track_out(track_out),
    .buf_rd_addr(buf_rd_addr),
    .buf_rd_req(buf_rd_req)
  );

  msu_buf_arbiter u_arb (
    .clkin(clkin),
    .reset(reset),
    .pgm_we(pgm_we),
    .pgm_address(pgm_address),
    .pgm_data(pgm_data),
    .buf_rd_req(buf_rd_req),
    .buf_rd_addr(buf_rd_addr),
    .buf_rd_grant(buf_rd_grant),
    .buf_rd_valid(buf_rd_valid),
    .ram_we(ram_we),
    .ram_addr(ram_addr),
    .ram_wdata(ram_wdata)
  );

  msu_databuf u_buf (
    .clkin(clkin),
    .we(ram_we),
    .addr(ram_addr),
    .wdata(ram_wdata),
    .rdata(buf_rd_data)
  );

endmodule

//--- testbench/msu_sva.sv
module msu_sva (
  input logic                clkin,
  input logic                reset,
  input logic                volume_latch_out,
  input logic                pgm_we,
  input logic                wr_grant,
  input msu_pkg::msu_flags_t flags
);
  timeunit 1ns;
  timeprecision 100ps;

  // Volume latch is a single-cycle strobe
  latch_one_cycle: assert property (@(posedge clkin) disable iff (reset)
    volume_latch_out |=> !volume_latch_out)
    else $error("volume_latch_out high for two cycles");

  // Held fill write gets the RAM port one or two cycles after its pulse
  wr_grant_in_time: assert property (@(posedge clkin) disable iff (reset)
    pgm_we |=> ##[0:1] wr_grant)
    else $error("held MCU write was not granted within two cycles");

  // Control request locked out while audio busy
  ctrl_gated: assert property (@(posedge clkin) disable iff (reset)
    $rose(flags[0]) |-> !$past(flags[5]))
    else $error("control request rose while audio busy was set");

endmodule

bind msu_top msu_sva u_sva (
  .clkin(clkin),
  .reset(reset),
  .volume_latch_out(volume_latch_out),
  .pgm_we(pgm_we),
  .wr_grant(u_arb.wr_grant),
  .flags(u_regs.flags)
);

//--- testbench/tb_msu.sv
module tb_msu;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {k_read, k_write, k_fill, k_addr, k_flags, k_out} step_kind_t;

  // sel picks the register, or the output for k_out
  // k_flags carries set bits in data[13:8] and clear bits in data[5:0]
  typedef struct packed {
    step_kind_t             kind;
    msu_pkg::msu_reg_sel_t  sel;
    msu_pkg::msu_buf_addr_t addr;
    logic [31:0]            data;
    logic [31:0]            exp;
  } step_t;

  logic                   clkin;
  logic                   reset;
  logic                   snes_rd;
  logic                   snes_wr;
  logic                   enable;
  msu_pkg::msu_reg_sel_t  reg_addr;
  msu_pkg::msu_byte_t     reg_data_in;
  msu_pkg::msu_byte_t     reg_data_out;
  msu_pkg::msu_buf_addr_t pgm_address;
  msu_pkg::msu_byte_t     pgm_data;
  logic                   pgm_we;
  msu_pkg::msu_buf_addr_t msu_address_ext;
  logic                   msu_address_ext_write;
  msu_pkg::msu_flags_t    status_set_bits;
  msu_pkg::msu_flags_t    status_reset_bits;
  logic                   status_reset_we;
  msu_pkg::msu_byte_t     status_out;
  msu_pkg::msu_seek_t     addr_out;
  msu_pkg::msu_track_t    track_out;
  msu_pkg::msu_byte_t     volume_out;
  logic                   volume_latch_out;

  step_t                  steps[$];
  int                     cycle_count = 0;
  int                     cycle_limit = 0;
  int                     latch_total = 0;

  // Reference model of flags, buffer and read address
  msu_pkg::msu_flags_t    model_flags;
  msu_pkg::msu_buf_addr_t model_addr;
  msu_pkg::msu_byte_t     model_mem [16384];

  msu_top #(
    .SYNC_STAGES(2)
  ) UUT (
    .clkin(clkin),
    .reset(reset),
    .snes_rd(snes_rd),
    .snes_wr(snes_wr),
    .enable(enable),
    .reg_addr(reg_addr),
    .reg_data_in(reg_data_in),
    .reg_data_out(reg_data_out),
    .pgm_address(pgm_address),
    .pgm_data(pgm_data),
    .pgm_we(pgm_we),
    .msu_address_ext(msu_address_ext),
    .msu_address_ext_write(msu_address_ext_write),
    .status_set_bits(status_set_bits),
    .status_reset_bits(status_reset_bits),
    .status_reset_we(status_reset_we),
    .status_out(status_out),
    .addr_out(addr_out),
    .track_out(track_out),
    .volume_out(volume_out),
    .volume_latch_out(volume_latch_out)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  always @(negedge clkin) begin
    if (volume_latch_out) begin
      latch_total <= latch_total + 1;
    end
  end

  always @(posedge clkin) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_with_error($sformatf("Timeout, the run was still going after %0d cycles",
                                cycle_count));
    end
  end

  //////////////////////////////
  // Error reporting and compares
  //////////////////////////////

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input msu_pkg::msu_byte_t got,
                            input msu_pkg::msu_byte_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_seek(input string name, input msu_pkg::msu_seek_t got,
                            input msu_pkg::msu_seek_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_track(input string name, input msu_pkg::msu_track_t got,
                             input msu_pkg::msu_track_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("ERR %s got 0x%04h expected 0x%04h", name, got, exp));
    end
  endtask

  // Data busy, audio busy, play/repeat, audio error, revision 1
  function automatic msu_pkg::msu_byte_t status_byte(input msu_pkg::msu_flags_t f);
    return {f[4], f[5], f[2:1], f[3], 3'b001};
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic add_step(input step_kind_t kind, input msu_pkg::msu_reg_sel_t sel,
                          input msu_pkg::msu_buf_addr_t addr, input logic [31:0] data,
                          input logic [31:0] exp);
    steps.push_back('{kind, sel, addr, data, exp});
  endtask

  // Reads of registers 0 and 1 take their expected value from the model
  task automatic build_table();
    msu_pkg::msu_buf_addr_t fill_addr [6] = '{14'h3FFD, 14'h3FFE, 14'h3FFF,
                                              14'h0000, 14'h0001, 14'h0002};
    msu_pkg::msu_byte_t     id_bytes [6]  = '{8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};
    // Reset state and ID string
    add_step(k_out, 3'd0, '0, '0, 32'h00);
    add_step(k_out, 3'd1, '0, '0, 32'h0);
    add_step(k_out, 3'd2, '0, '0, 32'h0);
    add_step(k_out, 3'd3, '0, '0, 32'h00);
    add_step(k_read, 3'd0, '0, '0, '0);
    for (int i = 0; i < 6; i++) begin
      add_step(k_read, 3'(i + 2), '0, '0, {24'h0, id_bytes[i]});
    end
    // Buffer fill and streaming reads across the wrap
    for (int i = 0; i < 6; i++) begin
      add_step(k_fill, 3'd0, fill_addr[i], $urandom % 256, '0);
    end
    add_step(k_addr, 3'd0, 14'h3FFD, '0, '0);
    add_step(k_out, 3'd0, '0, '0, 32'h80);
    for (int i = 0; i < 3; i++) begin
      add_step(k_read, 3'd1, '0, '0, '0);
    end
    add_step(k_out, 3'd0, '0, '0, 32'h00);
    for (int i = 0; i < 3; i++) begin
      add_step(k_read, 3'd1, '0, '0, '0);
    end
    // Seek offset and data busy
    add_step(k_flags, 3'd0, '0, 32'h0010, '0);
    add_step(k_read, 3'd0, '0, '0, '0);
    add_step(k_write, 3'd0, '0, 32'h78, '0);
    add_step(k_write, 3'd1, '0, 32'h56, '0);
    add_step(k_write, 3'd2, '0, 32'h34, '0);
    add_step(k_write, 3'd3, '0, 32'h12, '0);
    add_step(k_out, 3'd1, '0, '0, 32'h1234_5678);
    add_step(k_out, 3'd0, '0, '0, 32'h20);
    add_step(k_read, 3'd0, '0, '0, '0);
    add_step(k_flags, 3'd0, '0, 32'h0010, '0);
    add_step(k_out, 3'd0, '0, '0, 32'h00);
    add_step(k_read, 3'd0, '0, '0, '0);
    // Track, audio busy gating of the control write
    add_step(k_write, 3'd4, '0, 32'hCD, '0);
    add_step(k_write, 3'd5, '0, 32'hAB, '0);
    add_step(k_out, 3'd2, '0, '0, 32'hABCD);
    add_step(k_out, 3'd0, '0, '0, 32'h40);
    add_step(k_write, 3'd7, '0, 32'h05, '0);
    add_step(k_out, 3'd0, '0, '0, 32'h40);
    add_step(k_flags, 3'd0, '0, 32'h0E20, '0);
    add_step(k_read, 3'd0, '0, '0, '0);
    add_step(k_write, 3'd7, '0, 32'h05, '0);
    add_step(k_out, 3'd0, '0, '0, 32'h0B);
    add_step(k_read, 3'd0, '0, '0, '0);
    // Volume
    add_step(k_write, 3'd6, '0, 32'h9A, '0);
    add_step(k_out, 3'd3, '0, '0, 32'h9A);
    add_step(k_out, 3'd0, '0, '0, 32'h0B);
  endtask

  //////////////////////////////
  // Bus drivers
  //////////////////////////////

  task automatic console_access(input logic is_write, input msu_pkg::msu_reg_sel_t sel,
                                input msu_pkg::msu_byte_t data);
    @(posedge clkin);
    reg_addr    <= sel;
    reg_data_in <= data;
    if (is_write) begin
      snes_wr <= 1'b1;
    end else begin
      snes_rd <= 1'b1;
    end
    repeat (6) @(posedge clkin);
    snes_wr <= 1'b0;
    snes_rd <= 1'b0;
    repeat (10) @(posedge clkin);
  endtask

  task automatic apply_step(input step_t s, input int idx);
    msu_pkg::msu_byte_t exp_byte;
    int                 latch_before;
    latch_before = latch_total;
    case (s.kind)
      k_read: begin
        console_access(1'b0, s.sel, '0);
        @(negedge clkin);
        if (s.sel == 3'd0) begin
          exp_byte = status_byte(model_flags);
        end else if (s.sel == 3'd1) begin
          exp_byte   = model_mem[model_addr];
          model_addr = model_addr + 14'd1;
        end else begin
          exp_byte = s.exp[7:0];
        end
        check_byte("reg_data_out", reg_data_out, exp_byte);
      end
      k_write: begin
        console_access(1'b1, s.sel, s.data[7:0]);
        if (s.sel == 3'd3) begin
          model_flags[4] = 1'b1;
        end else if (s.sel == 3'd5) begin
          model_flags[5] = 1'b1;
        end else if (s.sel == 3'd7 && !model_flags[5]) begin
          model_flags[0] = 1'b1;
        end
      end
      k_fill: begin
        @(posedge clkin);
        pgm_address <= s.addr;
        pgm_data    <= s.data[7:0];
        pgm_we      <= 1'b1;
        @(posedge clkin);
        pgm_we <= 1'b0;
        repeat (10) @(posedge clkin);
        model_mem[s.addr] = s.data[7:0];
      end
      k_addr: begin
        @(posedge clkin);
        msu_address_ext       <= s.addr;
        msu_address_ext_write <= 1'b1;
        repeat (6) @(posedge clkin);
        msu_address_ext_write <= 1'b0;
        repeat (10) @(posedge clkin);
        model_addr = s.addr;
      end
      k_flags: begin
        @(posedge clkin);
        status_set_bits   <= s.data[13:8];
        status_reset_bits <= s.data[5:0];
        status_reset_we   <= 1'b1;
        repeat (6) @(posedge clkin);
        status_reset_we <= 1'b0;
        repeat (10) @(posedge clkin);
        model_flags = (model_flags | s.data[13:8]) & ~s.data[5:0];
      end
      default: begin
        @(negedge clkin);
        case (s.sel)
          3'd0: check_byte("status_out", status_out, s.exp[7:0]);
          3'd1: check_seek("addr_out", addr_out, s.exp);
          3'd2: check_track("track_out", track_out, s.exp[15:0]);
          default: check_byte("volume_out", volume_out, s.exp[7:0]);
        endcase
      end
    endcase
    // Exactly one latch pulse per volume write, none otherwise
    if ((latch_total - latch_before) != ((s.kind == k_write && s.sel == 3'd6) ? 1 : 0)) begin
      stop_with_error($sformatf("Wrong number of volume_latch_out pulses at step %0d", idx));
    end
  endtask

  initial begin
    void'($urandom(32'h610c_8045));
    reset                 = 1'b1;
    snes_rd               = 1'b0;
    snes_wr               = 1'b0;
    enable                = 1'b1;
    reg_addr              = '0;
    reg_data_in           = '0;
    pgm_address           = '0;
    pgm_data              = '0;
    pgm_we                = 1'b0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    status_set_bits       = '0;
    status_reset_bits     = '0;
    status_reset_we       = 1'b0;
    model_flags           = 6'b11_0000;
    model_addr            = '0;
    build_table();
    cycle_limit = steps.size() * 20 + 200;
    repeat (3) @(posedge clkin);
    reset <= 1'b0;
    foreach (steps[i]) begin
      apply_step(steps[i], i);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- tb.f
logic/msu_pkg.sv
logic/msu_bus_edge.sv
logic/msu_regs.sv
logic/msu_buf_arbiter.sv
logic/msu_databuf.sv
logic/msu_top.sv
testbench/msu_sva.sv
testbench/tb_msu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_msu
FILELIST   := tb.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
